// File: verilog/umode_pkg.sv
// user-mode checker package: mode codes, mstatus fields, insn patterns, causes and rule ids
package umode_pkg;

  typedef logic [1:0] mode_t;

  localparam mode_t MODE_U = 2'b00;
  localparam mode_t MODE_M = 2'b11;

  // mstatus field positions
  localparam int MPP_POS  = 11;
  localparam int MPRV_POS = 17;
  localparam int TW_POS   = 21;

  localparam logic [31:0] MRET_IDATA  = 32'h3020_0073;
  localparam logic [31:0] WFI_IDATA   = 32'h1050_0073;
  localparam logic [31:0] ECALL_IDATA = 32'h0000_0073;

  localparam logic [6:0] SYSTEM_OPCODE = 7'b1110011;

  // funct3 codes of the csr instructions
  localparam logic [2:0] F3_CSRRW  = 3'd1;
  localparam logic [2:0] F3_CSRRS  = 3'd2;
  localparam logic [2:0] F3_CSRRC  = 3'd3;
  localparam logic [2:0] F3_CSRRWI = 3'd5;
  localparam logic [2:0] F3_CSRRSI = 3'd6;
  localparam logic [2:0] F3_CSRRCI = 3'd7;

  localparam logic [5:0] CAUSE_INSTR_FAULT  = 6'd1;
  localparam logic [5:0] CAUSE_ILLEGAL      = 6'd2;
  localparam logic [5:0] CAUSE_ECALL_U      = 6'd8;
  localparam logic [5:0] CAUSE_INSTR_BUS    = 6'd24;
  localparam logic [5:0] CAUSE_INSTR_PARITY = 6'd25;

  localparam int NUM_RULES = 9;

  localparam int RULE_MODE       = 0;
  localparam int RULE_MSCRATCH_U = 1;
  localparam int RULE_MPP        = 2;
  localparam int RULE_MPRV_U     = 3;
  localparam int RULE_PRIV_INSN  = 4;
  localparam int RULE_ECALL_U    = 5;
  localparam int RULE_TRAP_TO_M  = 6;
  localparam int RULE_MRET_U     = 7;
  localparam int RULE_MRET_MPP   = 8;

  typedef logic [NUM_RULES-1:0] viol_t;

  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } sys_fields_t;

  // csr address split into access type, privilege level and index
  typedef struct packed {
    logic [1:0] csr_rw;
    logic [1:0] csr_priv;
    logic [7:0] csr_index;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } csr_fields_t;

  typedef union packed {
    sys_fields_t sys_fields;
    csr_fields_t csr_fields;
  } insn_u;

  // fetch faults outrank illegal-instruction and ecall causes
  function automatic logic cause_excused(input logic [5:0] cause);
    return cause inside {CAUSE_INSTR_FAULT, CAUSE_INSTR_BUS, CAUSE_INSTR_PARITY};
  endfunction

endpackage

// File: verilog/retire_if.sv
// retirement record carried from the checker top to the rule checkers
interface retire_if;

  logic                valid;
  umode_pkg::mode_t    mode;
  umode_pkg::insn_u    insn;
  logic                trap;
  logic [5:0]          cause;
  logic                intr;
  logic [31:0]         mstatus_rdata;
  logic [31:0]         mstatus_wdata;
  logic [31:0]         mstatus_wmask;
  logic [31:0]         mscratch_wmask;

  modport source (
    output valid,
    output mode,
    output insn,
    output trap,
    output cause,
    output intr,
    output mstatus_rdata,
    output mstatus_wdata,
    output mstatus_wmask,
    output mscratch_wmask
  );

  modport sink (
    input valid,
    input mode,
    input insn,
    input trap,
    input cause,
    input intr,
    input mstatus_rdata,
    input mstatus_wdata,
    input mstatus_wmask,
    input mscratch_wmask
  );

endinterface

// File: verilog/insn_rule_check.sv
// per-instruction privilege rules: mscratch, mpp, wfi, csr level and ecall
module insn_rule_check (
  retire_if.sink              ret,
  output umode_pkg::viol_t    insn_flags
);

  logic             is_umode;
  logic             is_wfi;
  logic             is_ecall;
  logic             is_csr;
  logic             csr_above_u;
  logic             tw;
  logic             trap_illegal;
  logic             trap_excused;
  logic             needs_priv;
  logic [31:0]      mstatus_post;
  umode_pkg::mode_t mpp_post;

  assign is_umode = (ret.mode == umode_pkg::MODE_U);
  assign is_wfi   = (ret.insn == umode_pkg::WFI_IDATA);
  assign is_ecall = (ret.insn == umode_pkg::ECALL_IDATA);

  // system opcode with a csr funct3
  assign is_csr = (ret.insn.sys_fields.opcode == umode_pkg::SYSTEM_OPCODE) &&
                  (ret.insn.sys_fields.funct3 inside {
                    umode_pkg::F3_CSRRW,  umode_pkg::F3_CSRRS,  umode_pkg::F3_CSRRC,
                    umode_pkg::F3_CSRRWI, umode_pkg::F3_CSRRSI, umode_pkg::F3_CSRRCI
                  });

  // same word read as a csr address
  assign csr_above_u = is_csr && (ret.insn.csr_fields.csr_priv != umode_pkg::MODE_U);

  assign tw = ret.mstatus_rdata[umode_pkg::TW_POS];

  assign trap_illegal = ret.trap && (ret.cause == umode_pkg::CAUSE_ILLEGAL);
  assign trap_excused = ret.trap && umode_pkg::cause_excused(ret.cause);

  assign needs_priv = is_umode && ((is_wfi && tw) || csr_above_u);

  // mstatus after the write: new bits under the mask, old bits elsewhere
  assign mstatus_post = (ret.mstatus_wdata & ret.mstatus_wmask) |
                        (ret.mstatus_rdata & ~ret.mstatus_wmask);
  assign mpp_post     = mstatus_post[umode_pkg::MPP_POS +: 2];

  always_comb begin
    insn_flags = '0;
    if (ret.valid) begin
      insn_flags[umode_pkg::RULE_MSCRATCH_U] = is_umode && (|ret.mscratch_wmask);

      insn_flags[umode_pkg::RULE_MPP] =
        !(mpp_post inside {umode_pkg::MODE_U, umode_pkg::MODE_M});

      // must trap as illegal, and wfi with tw clear must not
      insn_flags[umode_pkg::RULE_PRIV_INSN] =
        (needs_priv && !trap_illegal && !trap_excused) ||
        (is_umode && is_wfi && !tw && trap_illegal);

      insn_flags[umode_pkg::RULE_ECALL_U] =
        is_umode && is_ecall &&
        !(ret.trap && (ret.cause == umode_pkg::CAUSE_ECALL_U)) &&
        !trap_excused;
    end
  end

endmodule

// File: verilog/mode_seq_check.sv
// mode rules, some of which compare a retirement with the one before it
module mode_seq_check (
  input  logic                clk_i,
  input  logic                reset,
  retire_if.sink              ret,
  output umode_pkg::viol_t    mode_flags
);

  logic             is_umode;
  logic             is_mmode;
  logic             is_mret;
  logic             mret_trap_ok;
  logic             have_prev;
  logic             prev_trapped;
  logic             prev_mret_u;
  logic             prev_mret_m;
  umode_pkg::mode_t prev_mret_m_target;

  assign is_umode = (ret.mode == umode_pkg::MODE_U);
  assign is_mmode = (ret.mode == umode_pkg::MODE_M);
  assign is_mret  = (ret.insn == umode_pkg::MRET_IDATA);

  // an mret in user mode has to raise illegal, or a fetch fault ahead of it
  assign mret_trap_ok = ret.trap &&
                        ((ret.cause == umode_pkg::CAUSE_ILLEGAL) ||
                         umode_pkg::cause_excused(ret.cause));

  always_ff @(posedge clk_i) begin
    if (reset) begin
      have_prev    <= 1'b0;
      prev_trapped <= 1'b0;
      prev_mret_u  <= 1'b0;
      prev_mret_m  <= 1'b0;
    end else if (ret.valid) begin
      have_prev    <= 1'b1;
      prev_trapped <= ret.trap;
      prev_mret_u  <= is_umode && is_mret;
      prev_mret_m  <= is_mmode && is_mret && !ret.trap;
    end
  end

  // mpp as read by the mret, i.e. the mode it returns to
  always_ff @(posedge clk_i) begin
    if (ret.valid) begin
      prev_mret_m_target <= ret.mstatus_rdata[umode_pkg::MPP_POS +: 2];
    end
  end

  always_comb begin
    mode_flags = '0;
    if (ret.valid) begin
      mode_flags[umode_pkg::RULE_MODE]   = !(is_umode || is_mmode);
      mode_flags[umode_pkg::RULE_MPRV_U] = is_umode && ret.mstatus_rdata[umode_pkg::MPRV_POS];

      mode_flags[umode_pkg::RULE_MRET_U] = is_umode && is_mret && !mret_trap_ok;

      if (have_prev) begin
        mode_flags[umode_pkg::RULE_TRAP_TO_M] = prev_trapped && !is_mmode;
        mode_flags[umode_pkg::RULE_MRET_U]    = mode_flags[umode_pkg::RULE_MRET_U] ||
                                                (prev_mret_u && !is_mmode);
        // an interrupt taken right after the mret hides the target mode
        mode_flags[umode_pkg::RULE_MRET_MPP]  = prev_mret_m && !ret.intr &&
                                                (ret.mode != prev_mret_m_target);
      end
    end
  end

endmodule

// File: verilog/violation_collect.sv
// merges the rule flags, registers the result strobe and counts violating retirements
module violation_collect (
  input  logic                clk_i,
  input  logic                reset,
  input  logic                retire_valid,
  input  umode_pkg::viol_t    insn_flags,
  input  umode_pkg::viol_t    mode_flags,
  output logic                viol_valid,
  output umode_pkg::viol_t    viol_flags,
  output logic [15:0]         viol_count
);

  umode_pkg::viol_t merged;
  logic             any_viol;
  logic             count_full;

  // each group drives only its own bits
  assign merged     = insn_flags | mode_flags;
  assign any_viol   = |merged;
  assign count_full = &viol_count;

  always_ff @(posedge clk_i) begin
    if (reset) begin
      viol_valid <= 1'b0;
      viol_flags <= '0;
    end else begin
      viol_valid <= retire_valid;
      if (retire_valid) begin
        viol_flags <= merged;
      end
    end
  end

  // one count per retirement, however many rules it broke
  always_ff @(posedge clk_i) begin
    if (reset) begin
      viol_count <= '0;
    end else if (retire_valid && any_viol && !count_full) begin
      viol_count <= viol_count + 16'd1;
    end
  end

endmodule

// File: verilog/umode_checker.sv
// user-mode privilege checker top: retirement ports in, per-retirement rule flags out
module umode_checker (
  input  logic                clk_i,
  input  logic                reset,
  input  logic                retire_valid,
  input  umode_pkg::mode_t    retire_mode,
  input  logic [31:0]         retire_insn,
  input  logic                retire_trap,
  input  logic [5:0]          retire_cause,
  input  logic                retire_intr,
  input  logic [31:0]         mstatus_rdata,
  input  logic [31:0]         mstatus_wdata,
  input  logic [31:0]         mstatus_wmask,
  input  logic [31:0]         mscratch_wmask,
  output logic                viol_valid,
  output umode_pkg::viol_t    viol_flags,
  output logic [15:0]         viol_count
);

  umode_pkg::viol_t insn_flags;
  umode_pkg::viol_t mode_flags;

  retire_if u_ret ();

  assign u_ret.valid          = retire_valid;
  assign u_ret.mode           = retire_mode;
  assign u_ret.insn           = retire_insn;
  assign u_ret.trap           = retire_trap;
  assign u_ret.cause          = retire_cause;
  assign u_ret.intr           = retire_intr;
  assign u_ret.mstatus_rdata  = mstatus_rdata;
  assign u_ret.mstatus_wdata  = mstatus_wdata;
  assign u_ret.mstatus_wmask  = mstatus_wmask;
  assign u_ret.mscratch_wmask = mscratch_wmask;

  insn_rule_check u_insn_rule_check (
    .ret        (u_ret.sink),
    .insn_flags (insn_flags)
  );

  mode_seq_check u_mode_seq_check (
    .clk_i      (clk_i),
    .reset      (reset),
    .ret        (u_ret.sink),
    .mode_flags (mode_flags)
  );

  violation_collect u_violation_collect (
    .clk_i        (clk_i),
    .reset        (reset),
    .retire_valid (retire_valid),
    .insn_flags   (insn_flags),
    .mode_flags   (mode_flags),
    .viol_valid   (viol_valid),
    .viol_flags   (viol_flags),
    .viol_count   (viol_count)
  );

endmodule

// File: test/umode_checker_props.sv
// concurrent properties on the result strobe and the violation count of the collector
module umode_checker_props (
  input logic                clk_i,
  input logic                reset,
  input logic                viol_valid,
  input umode_pkg::viol_t    viol_flags,
  input logic [15:0]         viol_count
);
  timeunit 1ns;
  timeprecision 1ps;

  strobe_low_after_reset: assert property (@(posedge clk_i) reset |=> !viol_valid)
    else $error("result strobe high right after reset");

  count_monotonic: assert property (@(posedge clk_i)
    !reset |=> viol_count >= $past(viol_count))
    else $error("violation count went down");

  // count moves in the cycle its flagged result is shown, unless saturated
  count_tracks_flags: assert property (@(posedge clk_i)
    !reset |=> ((viol_count != $past(viol_count)) ==
                (viol_valid && (|viol_flags) && ($past(viol_count) != 16'hffff))))
    else $error("violation count does not follow the flagged results");

endmodule

bind violation_collect umode_checker_props u_props (
  .clk_i      (clk_i),
  .reset      (reset),
  .viol_valid (viol_valid),
  .viol_flags (viol_flags),
  .viol_count (viol_count)
);

// File: test/umode_checker_tb.sv
// testbench for the user-mode privilege checker with directed retirement sequences and result checks
module umode_checker_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          MAX_CYCLES  = 400;
  localparam logic [31:0] ADDI_IDATA  = 32'h0010_0093;
  // csrrs x1 on mstatus (machine level) and on cycle (user level)
  localparam logic [31:0] CSR_M_IDATA = 32'h3000_20f3;
  localparam logic [31:0] CSR_U_IDATA = 32'hc000_20f3;
  localparam logic [31:0] MS_MPP_M    = 32'h0000_1800;
  localparam logic [31:0] MS_TW       = 32'h0020_0000;
  localparam logic [31:0] MS_MPRV     = 32'h0002_0000;

  logic                clk_i;
  logic                reset;
  logic                retire_valid;
  umode_pkg::mode_t    retire_mode;
  logic [31:0]         retire_insn;
  logic                retire_trap;
  logic [5:0]          retire_cause;
  logic                retire_intr;
  logic [31:0]         mstatus_rdata;
  logic [31:0]         mstatus_wdata;
  logic [31:0]         mstatus_wmask;
  logic [31:0]         mscratch_wmask;
  logic                viol_valid;
  umode_pkg::viol_t    viol_flags;
  logic [15:0]         viol_count;

  int          cycles;
  int          err_count;
  int          test_errs;
  int          tests_ok;
  int          tests_bad;
  logic [15:0] exp_count;
  string       cur_test;

  umode_checker u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic umode_pkg::viol_t rule_mask(input int idx);
    rule_mask      = '0;
    rule_mask[idx] = 1'b1;
  endfunction

  // drives one record for a single cycle from one falling edge to the next
  task automatic retire(input umode_pkg::mode_t mode, input logic [31:0] insn,
                        input logic trap, input logic [5:0] cause, input logic [31:0] rdata);
    retire_valid  = 1'b1;
    retire_mode   = mode;
    retire_insn   = insn;
    retire_trap   = trap;
    retire_cause  = cause;
    mstatus_rdata = rdata;
    @(negedge clk_i);
    retire_valid   = 1'b0;
    retire_trap    = 1'b0;
    retire_intr    = 1'b0;
    mstatus_wdata  = '0;
    mstatus_wmask  = '0;
    mscratch_wmask = '0;
  endtask

  // result is due one cycle after the retirement
  task automatic expect_result(input umode_pkg::viol_t exp);
    if (exp != '0 && exp_count != 16'hffff) begin
      exp_count++;
    end
    if (viol_valid !== 1'b1) begin
      $display("%s: no result strobe one cycle after a retirement at %0t", cur_test, $time);
      err_count++;
    end else begin
      if (viol_flags !== exp) begin
        $display("ERR %0t viol_flags expected %b got %b", $time, exp, viol_flags);
        err_count++;
      end
      if (viol_count !== exp_count) begin
        $display("ERR %0t viol_count expected %0d got %0d", $time, exp_count, viol_count);
        err_count++;
      end
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (4) @(negedge clk_i);
    reset     = 1'b0;
    exp_count = '0;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = err_count;
  endtask

  task automatic finish_test();
    if (err_count == test_errs) begin
      tests_ok++;
      $display("test %s: ok", cur_test);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", cur_test, err_count - test_errs);
    end
  endtask

  task automatic clean_program();
    start_test("clean_program");
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, MS_MPP_M);
    expect_result('0);
    retire(umode_pkg::MODE_M, CSR_M_IDATA, 1'b0, 6'd0, MS_MPP_M);
    expect_result('0);
    // mret back to user with mpp holding U
    retire(umode_pkg::MODE_M, umode_pkg::MRET_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    retire(umode_pkg::MODE_U, ADDI_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    retire(umode_pkg::MODE_U, CSR_U_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    finish_test();
  endtask

  task automatic user_insn_rules();
    start_test("user_insn_rules");
    mscratch_wmask = 32'hffff_ffff;
    retire(umode_pkg::MODE_U, ADDI_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result(rule_mask(umode_pkg::RULE_MSCRATCH_U));
    retire(umode_pkg::MODE_U, umode_pkg::WFI_IDATA, 1'b0, 6'd0, MS_TW);
    expect_result(rule_mask(umode_pkg::RULE_PRIV_INSN));
    retire(umode_pkg::MODE_U, umode_pkg::WFI_IDATA, 1'b1, umode_pkg::CAUSE_ILLEGAL, MS_TW);
    expect_result('0);
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    // bus fault on fetch outranks the illegal csr access
    retire(umode_pkg::MODE_U, CSR_M_IDATA, 1'b1, umode_pkg::CAUSE_INSTR_BUS, 32'h0);
    expect_result('0);
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    retire(umode_pkg::MODE_U, umode_pkg::ECALL_IDATA, 1'b1, umode_pkg::CAUSE_ECALL_U, 32'h0);
    expect_result('0);
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    retire(umode_pkg::MODE_U, umode_pkg::ECALL_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result(rule_mask(umode_pkg::RULE_ECALL_U));
    finish_test();
  endtask

  task automatic mpp_writes();
    start_test("mpp_writes");
    mstatus_wdata = 32'h0000_0800;
    mstatus_wmask = MS_MPP_M;
    retire(umode_pkg::MODE_M, CSR_M_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result(rule_mask(umode_pkg::RULE_MPP));
    mstatus_wdata = 32'h0000_0800;
    retire(umode_pkg::MODE_M, CSR_M_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    finish_test();
  endtask

  task automatic sequence_rules();
    start_test("sequence_rules");
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b1, umode_pkg::CAUSE_ILLEGAL, 32'h0);
    expect_result('0);
    // state from the trapped retirement outlives the idle gap
    repeat (3) @(negedge clk_i);
    if (viol_valid !== 1'b0) begin
      $display("ERR %0t viol_valid expected 0 got %b", $time, viol_valid);
      err_count++;
    end
    retire(umode_pkg::MODE_U, ADDI_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result(rule_mask(umode_pkg::RULE_TRAP_TO_M));
    retire(umode_pkg::MODE_M, umode_pkg::MRET_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, MS_MPP_M);
    expect_result(rule_mask(umode_pkg::RULE_MRET_MPP));
    retire(umode_pkg::MODE_M, umode_pkg::MRET_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    retire_intr = 1'b1;
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, MS_MPP_M);
    expect_result('0);
    retire(umode_pkg::MODE_U, umode_pkg::MRET_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result(rule_mask(umode_pkg::RULE_MRET_U));
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, MS_MPP_M);
    expect_result('0);
    finish_test();
  endtask

  task automatic mode_and_mprv();
    start_test("mode_and_mprv");
    retire(2'b10, ADDI_IDATA, 1'b0, 6'd0, MS_MPP_M);
    expect_result(rule_mask(umode_pkg::RULE_MODE));
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, MS_MPP_M);
    expect_result('0);
    retire(umode_pkg::MODE_U, ADDI_IDATA, 1'b0, 6'd0, MS_MPRV);
    expect_result(rule_mask(umode_pkg::RULE_MPRV_U));
    // three rules at once count only once
    mscratch_wmask = 32'h1;
    retire(umode_pkg::MODE_U, umode_pkg::ECALL_IDATA, 1'b0, 6'd0, MS_MPRV);
    expect_result(rule_mask(umode_pkg::RULE_MSCRATCH_U) | rule_mask(umode_pkg::RULE_MPRV_U) |
                  rule_mask(umode_pkg::RULE_ECALL_U));
    finish_test();
  endtask

  task automatic back_to_back_and_reset();
    start_test("back_to_back_and_reset");
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b1, umode_pkg::CAUSE_ILLEGAL, MS_MPP_M);
    expect_result('0);
    retire(umode_pkg::MODE_U, ADDI_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result(rule_mask(umode_pkg::RULE_TRAP_TO_M));
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b0, 6'd0, MS_MPP_M);
    expect_result('0);
    retire(umode_pkg::MODE_M, ADDI_IDATA, 1'b1, umode_pkg::CAUSE_ILLEGAL, MS_MPP_M);
    expect_result('0);
    apply_reset();
    if (viol_valid !== 1'b0) begin
      $display("ERR %0t viol_valid expected 0 got %b", $time, viol_valid);
      err_count++;
    end
    if (viol_count !== 16'd0) begin
      $display("ERR %0t viol_count expected 0 got %0d", $time, viol_count);
      err_count++;
    end
    // trap before the reset must not carry over
    retire(umode_pkg::MODE_U, ADDI_IDATA, 1'b0, 6'd0, 32'h0);
    expect_result('0);
    finish_test();
  endtask

  initial begin
    reset          = 1'b1;
    retire_valid   = 1'b0;
    retire_mode    = umode_pkg::MODE_M;
    retire_insn    = '0;
    retire_trap    = 1'b0;
    retire_cause   = '0;
    retire_intr    = 1'b0;
    mstatus_rdata  = '0;
    mstatus_wdata  = '0;
    mstatus_wmask  = '0;
    mscratch_wmask = '0;
    cycles         = 0;
    err_count      = 0;
    tests_ok       = 0;
    tests_bad      = 0;
    exp_count      = '0;
    apply_reset();
    clean_program();
    user_insn_rules();
    mpp_writes();
    sequence_rules();
    mode_and_mprv();
    back_to_back_and_reset();
    $display("summary: %0d clean, %0d with errors, %0d errors", tests_ok, tests_bad, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
verilog/umode_pkg.sv
verilog/retire_if.sv
verilog/insn_rule_check.sv
verilog/mode_seq_check.sv
verilog/violation_collect.sv
verilog/umode_checker.sv
test/umode_checker_props.sv
test/umode_checker_tb.sv

// File: Bender.yml
package:
  name: umode_checker

sources:
  - verilog/umode_pkg.sv
  - verilog/retire_if.sv
  - verilog/insn_rule_check.sv
  - verilog/mode_seq_check.sv
  - verilog/violation_collect.sv
  - verilog/umode_checker.sv
  - target: test
    files:
      - test/umode_checker_props.sv
      - test/umode_checker_tb.sv
